// File: source/cache_pkg.sv
package cache_pkg;

    // Geometry: 2 ways, 4 lanes, 4 words per line
    localparam int ways_w = 1;
    localparam int ways = 2;
    localparam int lanes_w = 2;
    localparam int lanes = 4;
    localparam int offset_w = 2;
    localparam int words_per_line = 4;
    // Physical tag is what remains above lane, offset and byte bits
    localparam int tag_w = 32 - lanes_w - offset_w - 2;

    // Load access codes, others are unknown
    typedef logic [2:0] load_type_t;
    localparam load_type_t lb = 3'd0;
    localparam load_type_t lh = 3'd1;
    localparam load_type_t lw = 3'd2;
    localparam load_type_t lbu = 3'd4;
    localparam load_type_t lhu = 3'd5;

    // Store access codes, 3 is unknown
    typedef logic [1:0] store_type_t;
    localparam store_type_t sb = 2'd0;
    localparam store_type_t sh = 2'd1;
    localparam store_type_t sw = 2'd2;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [lanes_w-1:0]  lane;
        logic [offset_w-1:0] offset;
        logic [1:0]          inword;
    } cache_addr_fields_t;

    // Same word seen as byte address or as cache fields
    typedef union packed {
        logic [31:0]        raw;
        cache_addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        cache_addr_u addr;
        logic        load;
        logic        store;
        load_type_t  load_type;
        store_type_t store_type;
        logic [31:0] store_data;
    } core_req_t;

    typedef struct packed {
        logic        done;
        logic [31:0] load_data;
        logic        load_missaligned;
        logic        load_unknowntype;
        logic        store_missaligned;
        logic        store_unknowntype;
    } core_rsp_t;

    // Full-word transfers only
    typedef struct packed {
        cache_addr_u address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } mem_req_t;

endpackage

// File: source/cache_load_gen.sv
module cache_load_gen (
    input  logic [1:0]            inword_offset,
    input  cache_pkg::load_type_t load_type,
    input  logic [31:0]           data_in,
    output logic [31:0]           data_out,
    output logic                  missaligned,
    output logic                  unknowntype
);
    import cache_pkg::*;

    logic [31:0] shifted;

    // Addressed byte or halfword moved down to bit 0
    assign shifted = data_in >> {inword_offset, 3'b000};

    always_comb begin
        data_out = data_in;
        missaligned = 1'b0;
        unknowntype = 1'b0;
        case (load_type)
            lb:  data_out = {{24{shifted[7]}}, shifted[7:0]};
            lbu: data_out = {24'd0, shifted[7:0]};
            lh: begin
                data_out = {{16{shifted[15]}}, shifted[15:0]};
                // Halfword must sit on an even byte
                missaligned = inword_offset[0];
            end
            lhu: begin
                data_out = {16'd0, shifted[15:0]};
                missaligned = inword_offset[0];
            end
            lw:  missaligned = |inword_offset;
            default: unknowntype = 1'b1;
        endcase
    end

endmodule

// File: source/cache_store_gen.sv
module cache_store_gen (
    input  logic [1:0]             inword_offset,
    input  cache_pkg::store_type_t store_type,
    input  logic [31:0]            data_in,
    output logic [31:0]            data_out,
    output logic [3:0]             mask,
    output logic                   missaligned,
    output logic                   unknowntype
);
    import cache_pkg::*;

    always_comb begin
        data_out = data_in;
        mask = 4'b0000;
        missaligned = 1'b0;
        unknowntype = 1'b0;
        case (store_type)
            sb: begin
                // Byte copied to all lanes, mask picks one
                data_out = {4{data_in[7:0]}};
                mask = 4'b0001 << inword_offset;
            end
            sh: begin
                data_out = {2{data_in[15:0]}};
                mask = inword_offset[1] ? 4'b1100 : 4'b0011;
                missaligned = inword_offset[0];
            end
            sw: begin
                mask = 4'b1111;
                missaligned = |inword_offset;
            end
            default: unknowntype = 1'b1;
        endcase
        // Bad store touches no byte
        if (missaligned || unknowntype) begin
            mask = 4'b0000;
        end
    end

endmodule

// File: source/cache_ways.sv
module cache_ways (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rd_en,
    input  logic [cache_pkg::lanes_w-1:0] rd_lane,
    input  logic [cache_pkg::offset_w-1:0] rd_offset,
    input  logic                          wr_en,
    input  logic [cache_pkg::ways_w-1:0]  wr_way,
    input  logic [cache_pkg::lanes_w-1:0] wr_lane,
    input  logic [cache_pkg::offset_w-1:0] wr_offset,
    input  logic [31:0]                   wr_data,
    input  logic [3:0]                    wr_mask,
    input  logic                          tag_wr,
    input  logic [cache_pkg::tag_w-1:0]   tag_wr_tag,
    input  logic                          set_dirty,
    input  logic                          clr_dirty,
    input  logic [cache_pkg::tag_w-1:0]   cmp_tag,
    input  logic [cache_pkg::ways_w-1:0]  victim_way,
    output logic                          hit_any,
    output logic [cache_pkg::ways_w-1:0]  hit_way,
    output logic [31:0]                   hit_data,
    output logic [cache_pkg::tag_w-1:0]   victim_tag,
    output logic                          victim_valid,
    output logic                          victim_dirty,
    output logic [31:0]                   victim_data
);
    import cache_pkg::*;

    logic [31:0]      data_mem [ways][lanes*words_per_line];
    logic [tag_w-1:0] tag_mem [ways][lanes];
    logic [lanes-1:0] valid [ways];
    logic [lanes-1:0] dirty [ways];
    // Registered read port, one copy per way
    logic [31:0]      data_q [ways];
    logic [tag_w-1:0] tag_q [ways];
    logic [ways-1:0]  valid_q;
    logic [ways-1:0]  dirty_q;
    logic [ways-1:0]  hit;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    data_mem[wr_way][{wr_lane, wr_offset}][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        if (tag_wr) begin
            tag_mem[wr_way][wr_lane] <= tag_wr_tag;
        end
        // Old contents seen when read and write share an edge
        if (rd_en) begin
            for (int w = 0; w < ways; w++) begin
                data_q[w] <= data_mem[w][{rd_lane, rd_offset}];
                tag_q[w] <= tag_mem[w][rd_lane];
                valid_q[w] <= valid[w][rd_lane];
                dirty_q[w] <= dirty[w][rd_lane];
            end
        end
    end

    // Line flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < ways; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
        end else begin
            // New tag means a clean, valid line
            if (tag_wr) begin
                valid[wr_way][wr_lane] <= 1'b1;
                dirty[wr_way][wr_lane] <= 1'b0;
            end
            if (set_dirty) begin
                dirty[wr_way][wr_lane] <= 1'b1;
            end
            if (clr_dirty) begin
                dirty[wr_way][wr_lane] <= 1'b0;
            end
        end
    end

    // Tag compare, lowest way wins
    always_comb begin
        hit_way = '0;
        for (int w = ways - 1; w >= 0; w--) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
            if (hit[w]) begin
                hit_way = ways_w'(w);
            end
        end
    end

    assign hit_any = |hit;
    assign hit_data = data_q[hit_way];

    // Victim view for writeback
    assign victim_tag = tag_q[victim_way];
    assign victim_valid = valid_q[victim_way];
    assign victim_dirty = dirty_q[victim_way];
    assign victim_data = data_q[victim_way];

endmodule

// File: source/cache_ctrl.sv
module cache_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cache_pkg::core_req_t           c_req,
    input  logic                           c_flush,
    output logic                           c_done,
    output logic                           c_flush_done,
    input  logic                           m_waitrequest,
    input  logic [31:0]                    m_readdata,
    input  logic                           m_readdatavalid,
    output cache_pkg::mem_req_t            m_req,
    output logic                           rd_en,
    output logic [cache_pkg::lanes_w-1:0]  rd_lane,
    output logic [cache_pkg::offset_w-1:0] rd_offset,
    output logic                           wr_en,
    output logic [cache_pkg::ways_w-1:0]   wr_way,
    output logic [cache_pkg::lanes_w-1:0]  wr_lane,
    output logic [cache_pkg::offset_w-1:0] wr_offset,
    output logic [31:0]                    wr_data,
    output logic [3:0]                     wr_mask,
    output logic                           tag_wr,
    output logic [cache_pkg::tag_w-1:0]    tag_wr_tag,
    output logic                           set_dirty,
    output logic                           clr_dirty,
    output logic [cache_pkg::ways_w-1:0]   victim_way,
    input  logic                           hit_any,
    input  logic [cache_pkg::ways_w-1:0]   hit_way,
    input  logic [cache_pkg::tag_w-1:0]    victim_tag,
    input  logic                           victim_valid,
    input  logic                           victim_dirty,
    input  logic [31:0]                    victim_data,
    input  logic [3:0]                     store_mask,
    input  logic [31:0]                    store_data,
    input  logic                           gen_error
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_flush_all
    } state_t;

    state_t              state;
    logic                flushing;
    logic [ways_w-1:0]   rr_ptr;
    logic [offset_w-1:0] cnt;
    logic                cnt_last;
    // Writeback word loaded in read register
    logic                wb_ready;
    // Refill read request outstanding, refill finished
    logic                rf_req;
    logic                rf_fin;
    // Flush walk position, second cycle of a slot
    logic                fl_chk;
    logic [lanes_w-1:0]  fl_lane;
    logic [ways_w-1:0]   fl_way;
    logic                fl_last;
    logic [lanes_w-1:0]  cur_lane;
    logic                victim_wb;

    assign cnt_last = cnt == offset_w'(words_per_line - 1);
    assign fl_last = (fl_lane == lanes_w'(lanes - 1)) && (fl_way == ways_w'(ways - 1));
    // Flush walks its own lane and way, requests use address lane and pointer
    assign cur_lane = flushing ? fl_lane : c_req.addr.f.lane;
    assign victim_way = flushing ? fl_way : rr_ptr;
    assign victim_wb = victim_valid && victim_dirty;
    assign rd_lane = cur_lane;
    assign wr_lane = cur_lane;
    assign tag_wr_tag = c_req.addr.f.tag;

    assign c_done = (state == st_lookup) && (gen_error || hit_any);
    assign c_flush_done = (state == st_flush_all) && fl_chk && !victim_wb && fl_last;

    // Storage commands
    always_comb begin
        rd_en = 1'b0;
        rd_offset = c_req.addr.f.offset;
        wr_en = 1'b0;
        wr_way = victim_way;
        wr_offset = c_req.addr.f.offset;
        wr_data = store_data;
        wr_mask = store_mask;
        tag_wr = 1'b0;
        set_dirty = 1'b0;
        clr_dirty = 1'b0;
        case (state)
            st_idle: rd_en = (c_req.load || c_req.store) && !c_flush;
            st_lookup: begin
                if (!gen_error && hit_any && c_req.store) begin
                    // Merge store bytes into the hit word
                    wr_en = 1'b1;
                    wr_way = hit_way;
                    set_dirty = 1'b1;
                end else if (!gen_error && !hit_any) begin
                    // Fetch word 0 of victim for possible writeback
                    rd_en = 1'b1;
                    rd_offset = '0;
                end
            end
            st_writeback: begin
                rd_offset = cnt + 1'b1;
                if (wb_ready && !m_waitrequest) begin
                    clr_dirty = cnt_last;
                    rd_en = !cnt_last;
                end
            end
            st_refill: begin
                if (rf_fin) begin
                    // Reread the requested word for the lookup
                    rd_en = 1'b1;
                end else if (m_readdatavalid) begin
                    wr_en = 1'b1;
                    wr_offset = cnt;
                    wr_data = m_readdata;
                    wr_mask = 4'b1111;
                    tag_wr = cnt_last;
                end
            end
            st_flush_all: begin
                rd_en = 1'b1;
                rd_offset = '0;
            end
            default: rd_en = 1'b0;
        endcase
    end

    // Memory port
    always_comb begin
        m_req.address.f.tag = (state == st_writeback) ? victim_tag : c_req.addr.f.tag;
        m_req.address.f.lane = cur_lane;
        m_req.address.f.offset = cnt;
        m_req.address.f.inword = 2'b00;
        m_req.read = (state == st_refill) && rf_req;
        m_req.write = (state == st_writeback) && wb_ready;
        m_req.writedata = victim_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            flushing <= 1'b0;
            rr_ptr <= '0;
            cnt <= '0;
            wb_ready <= 1'b0;
            rf_req <= 1'b0;
            rf_fin <= 1'b0;
            fl_chk <= 1'b0;
            fl_lane <= '0;
            fl_way <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (c_flush) begin
                        state <= st_flush_all;
                        flushing <= 1'b1;
                        fl_lane <= '0;
                        fl_way <= '0;
                        fl_chk <= 1'b0;
                    end else if (c_req.load || c_req.store) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (gen_error || hit_any) begin
                        state <= st_idle;
                    end else if (victim_wb) begin
                        state <= st_writeback;
                        cnt <= '0;
                        wb_ready <= 1'b0;
                    end else begin
                        state <= st_refill;
                        cnt <= '0;
                        rf_req <= 1'b1;
                    end
                end
                st_writeback: begin
                    if (!wb_ready) begin
                        wb_ready <= 1'b1;
                    end else if (!m_waitrequest) begin
                        // Word accepted, counter wraps to 0 on the last one
                        wb_ready <= 1'b0;
                        cnt <= cnt + 1'b1;
                        if (cnt_last && flushing) begin
                            state <= st_flush_all;
                        end else if (cnt_last) begin
                            state <= st_refill;
                            rf_req <= 1'b1;
                        end
                    end
                end
                st_refill: begin
                    if (rf_fin) begin
                        state <= st_lookup;
                        rf_fin <= 1'b0;
                        rr_ptr <= rr_ptr + 1'b1;
                    end else begin
                        if (rf_req && !m_waitrequest) begin
                            rf_req <= 1'b0;
                        end
                        if (m_readdatavalid) begin
                            cnt <= cnt + 1'b1;
                            rf_fin <= cnt_last;
                            rf_req <= !cnt_last;
                        end
                    end
                end
                st_flush_all: begin
                    fl_chk <= !fl_chk;
                    // Slot rechecked after writeback, then found clean
                    if (fl_chk && victim_wb) begin
                        state <= st_writeback;
                        wb_ready <= 1'b0;
                    end else if (fl_chk && fl_last) begin
                        state <= st_idle;
                        flushing <= 1'b0;
                    end else if (fl_chk) begin
                        {fl_way, fl_lane} <= {fl_way, fl_lane} + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: source/cache_top.sv
module cache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::core_req_t c_req,
    input  logic                 c_flush,
    output cache_pkg::core_rsp_t c_rsp,
    output logic                 c_flush_done,
    output cache_pkg::mem_req_t  m_req,
    input  logic                 m_waitrequest,
    input  logic [31:0]          m_readdata,
    input  logic                 m_readdatavalid
);
    import cache_pkg::*;

    logic                rd_en;
    logic [lanes_w-1:0]  rd_lane;
    logic [offset_w-1:0] rd_offset;
    logic                wr_en;
    logic [ways_w-1:0]   wr_way;
    logic [lanes_w-1:0]  wr_lane;
    logic [offset_w-1:0] wr_offset;
    logic [31:0]         wr_data;
    logic [3:0]          wr_mask;
    logic                tag_wr;
    logic [tag_w-1:0]    tag_wr_tag;
    logic                set_dirty;
    logic                clr_dirty;
    logic [ways_w-1:0]   victim_way;
    logic                hit_any;
    logic [ways_w-1:0]   hit_way;
    logic [31:0]         hit_data;
    logic [tag_w-1:0]    victim_tag;
    logic                victim_valid;
    logic                victim_dirty;
    logic [31:0]         victim_data;
    logic [3:0]          store_mask;
    logic [31:0]         store_data;
    logic                gen_error;

    // Error of the access actually requested
    assign gen_error = (c_req.load && (c_rsp.load_missaligned || c_rsp.load_unknowntype))
                    || (c_req.store && (c_rsp.store_missaligned || c_rsp.store_unknowntype));

    cache_ctrl ctrl0 (
        .clk, .rst_n, .c_req, .c_flush,
        .c_done(c_rsp.done), .c_flush_done,
        .m_waitrequest, .m_readdata, .m_readdatavalid, .m_req,
        .rd_en, .rd_lane, .rd_offset,
        .wr_en, .wr_way, .wr_lane, .wr_offset, .wr_data, .wr_mask,
        .tag_wr, .tag_wr_tag, .set_dirty, .clr_dirty, .victim_way,
        .hit_any, .hit_way, .victim_tag, .victim_valid, .victim_dirty, .victim_data,
        .store_mask, .store_data, .gen_error
    );

    cache_ways ways0 (
        .clk, .rst_n, .rd_en, .rd_lane, .rd_offset,
        .wr_en, .wr_way, .wr_lane, .wr_offset, .wr_data, .wr_mask,
        .tag_wr, .tag_wr_tag, .set_dirty, .clr_dirty,
        .cmp_tag(c_req.addr.f.tag), .victim_way,
        .hit_any, .hit_way, .hit_data,
        .victim_tag, .victim_valid, .victim_dirty, .victim_data
    );

    cache_load_gen loadgen0 (
        .inword_offset(c_req.addr.f.inword),
        .load_type(c_req.load_type),
        .data_in(hit_data),
        .data_out(c_rsp.load_data),
        .missaligned(c_rsp.load_missaligned),
        .unknowntype(c_rsp.load_unknowntype)
    );

    cache_store_gen storegen0 (
        .inword_offset(c_req.addr.f.inword),
        .store_type(c_req.store_type),
        .data_in(c_req.store_data),
        .data_out(store_data),
        .mask(store_mask),
        .missaligned(c_rsp.store_missaligned),
        .unknowntype(c_rsp.store_unknowntype)
    );

endmodule

// File: sim/cache_asserts.sv
module cache_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input cache_pkg::core_rsp_t c_rsp,
    input logic                 c_flush_done,
    input cache_pkg::mem_req_t  m_req,
    input logic                 m_waitrequest
);
    // Failure count, read by the testbench at the end of the run
    int assert_fails = 0;

    // One transfer direction at a time
    read_write_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(m_req.read && m_req.write))
        else begin
            $error("memory read and write requested together");
            assert_fails++;
        end

    // Stalled request keeps address, data and command
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (m_req.read || m_req.write) && m_waitrequest |=> $stable(m_req))
        else begin
            $error("memory request changed while stalled");
            assert_fails++;
        end

    // Access and flush never finish together
    done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(c_rsp.done && c_flush_done))
        else begin
            $error("done and flush_done high together");
            assert_fails++;
        end

endmodule

// File: sim/cache_tb.sv
module cache_tb;
    import cache_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n;
    core_req_t   c_req;
    logic        c_flush;
    core_rsp_t   c_rsp;
    logic        c_flush_done;
    mem_req_t    m_req;
    logic        m_waitrequest;
    logic [31:0] m_readdata;
    logic        m_readdatavalid;

    // Memory model, golden core view, record of accepted writes
    logic [31:0] mem [64];
    logic [31:0] golden [64];
    logic [31:0] shadow [64];
    logic        stored [64];
    logic [31:0] lfsr = 32'hb8cc_1daf;
    logic        rd_pending;
    logic [5:0]  rd_index;
    logic [5:0]  wr_index;
    int          errors;
    logic        aborted;

    cache_top dut0 (
        .clk, .rst_n, .c_req, .c_flush, .c_rsp, .c_flush_done,
        .m_req, .m_waitrequest, .m_readdata, .m_readdatavalid
    );

    bind cache_top cache_asserts asserts0 (
        .clk, .rst_n, .c_rsp, .c_flush_done, .m_req, .m_waitrequest
    );

    always #10 clk = ~clk;

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Halfword on even byte, word on offset 0
    function automatic logic store_ok(input logic [1:0] typ, input logic [1:0] ofs);
        return (typ == 2'd0) || (typ == 2'd1 && !ofs[0]) || (typ == 2'd2 && ofs == 2'd0);
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [1:0] typ,
                                                input logic [1:0] ofs, input logic [31:0] data);
        logic [31:0] w;
        w = old;
        case (typ)
            2'd0: w[8*ofs +: 8] = data[7:0];
            2'd1: w[16*ofs[1] +: 16] = data[15:0];
            default: w = data;
        endcase
        return w;
    endfunction

    // Memory side driven on falling edges
    always @(negedge clk) begin
        m_readdatavalid = 1'b0;
        if (rd_pending) begin
            // Data for the read accepted at the last rising edge
            m_readdatavalid = 1'b1;
            m_readdata = mem[rd_index];
            rd_pending = 1'b0;
        end
        m_waitrequest = lfsr[0];
        lfsr = lfsr_step(lfsr);
        // Request seen now is accepted at the next rising edge
        if (m_req.read === 1'b1 && !m_waitrequest) begin
            rd_pending = 1'b1;
            rd_index = m_req.address.raw[7:2];
        end
        if (m_req.write === 1'b1 && !m_waitrequest) begin
            wr_index = m_req.address.raw[7:2];
            mem[wr_index] = m_req.writedata;
            shadow[wr_index] = m_req.writedata;
            // Written word must match the latest core view
            compare_value("m_req.writedata", m_req.writedata, golden[wr_index]);
        end
    end

    // Poll at falling edges until done or timeout
    task automatic wait_for_done(input bit flush);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(flush ? c_flush_done : c_rsp.done) && cycles < 1000);
        if (!(flush ? c_flush_done : c_rsp.done)) begin
            $display("Timeout at %0t: %s never finished", $time, flush ? "flush" : "access");
            aborted = 1'b1;
        end
    endtask

    task automatic run_access(input bit is_store, input logic [31:0] typ,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic [1:0] err);
        logic [1:0] got_err;
        c_req.addr.raw = addr;
        c_req.load = !is_store;
        c_req.store = is_store;
        c_req.load_type = typ[2:0];
        c_req.store_type = typ[1:0];
        c_req.store_data = is_store ? data : 32'h0;
        wait_for_done(1'b0);
        if (!aborted) begin
            if (is_store) begin
                got_err = {c_rsp.store_unknowntype, c_rsp.store_missaligned};
            end else begin
                got_err = {c_rsp.load_unknowntype, c_rsp.load_missaligned};
            end
            compare_value(is_store ? "store error flags" : "load error flags",
                          32'(got_err), 32'(err));
            if (!is_store && err == 2'd0) begin
                compare_value("c_rsp.load_data", c_rsp.load_data, data);
            end
            // Golden view follows the store byte rules
            if (is_store && store_ok(typ[1:0], addr[1:0])) begin
                golden[addr[7:2]] = merge_store(golden[addr[7:2]], typ[1:0], addr[1:0], data);
                stored[addr[7:2]] = 1'b1;
            end
            // Request stays up through the done cycle
            @(negedge clk);
        end
        c_req.load = 1'b0;
        c_req.store = 1'b0;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [63:0] op;
        logic [31:0] typ;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] err;
        c_req = '0;
        c_flush = 1'b0;
        rst_n = 1'b0;
        m_waitrequest = 1'b1;
        m_readdata = 32'h0;
        m_readdatavalid = 1'b0;
        rd_pending = 1'b0;
        errors = 0;
        aborted = 1'b0;
        repeat (8) @(negedge clk);
        // Outputs quiet out of reset
        compare_value("c_rsp.done", 32'(c_rsp.done), 32'h0);
        compare_value("c_flush_done", 32'(c_flush_done), 32'h0);
        compare_value("m_req.read", 32'(m_req.read), 32'h0);
        compare_value("m_req.write", 32'(m_req.write), 32'h0);
        rst_n = 1'b1;

        fd = $fopen("sim/cache_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file sim/cache_stim.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && $fgets(line, fd) > 0) begin
                // Blank and comment lines
                if (line.len() < 3 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %h %h %h %h", op, typ, addr, data, err);
                if (n != 5) begin
                    $display("Malformed stimulus line: %s", line);
                    errors++;
                end else if (op == "fill") begin
                    // Each byte is its own address mixed with the base
                    for (int i = 0; i < 64; i++) begin
                        mem[i] = data ^ {8'(4*i+3), 8'(4*i+2), 8'(4*i+1), 8'(4*i)};
                        golden[i] = mem[i];
                        shadow[i] = 32'h0;
                        stored[i] = 1'b0;
                    end
                end else if (op == "load") begin
                    run_access(1'b0, typ, addr, data, err[1:0]);
                end else if (op == "store") begin
                    run_access(1'b1, typ, addr, data, err[1:0]);
                end else if (op == "flush") begin
                    c_flush = 1'b1;
                    wait_for_done(1'b1);
                    c_flush = 1'b0;
                    // Every stored word now in memory
                    for (int i = 0; i < 64; i++) begin
                        if (stored[i]) begin
                            compare_value($sformatf("shadow[%0d]", i), shadow[i], golden[i]);
                        end
                    end
                end else if (op == "shadow") begin
                    compare_value($sformatf("shadow[%0d]", addr[7:2]), shadow[addr[7:2]], data);
                end else begin
                    $display("Unknown operation in stimulus file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end

        $display("Run complete: %0d errors, %0d assertion failures, aborted %0d",
                 errors, dut0.asserts0.assert_fails, aborted);
        if (errors == 0 && dut0.asserts0.assert_fails == 0 && !aborted) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim/cache_stim.txt
# op type addr data err (hex); load data is the expected value, err 1 misaligned 2 unknown
# fill: word at byte address a holds base xor its four byte addresses
fill   0 00000000 80808080 0
load   2 00000010 93929190 0
load   0 00000011 ffffff91 0
load   4 00000013 00000093 0
load   1 00000012 ffff9392 0
load   5 00000014 00009594 0
load   2 00000098 1b1a1918 0
load   0 0000009b 0000001b 0
load   1 0000009a 00001b1a 0
store  0 00000021 000000a5 0
store  1 00000022 00007e5c 0
load   2 00000020 7e5ca5a0 0
store  2 00000024 12345678 0
load   1 00000026 00001234 0
load   0 00000024 00000078 0
load   1 00000023 00000000 1
load   2 00000022 00000000 1
load   3 00000020 00000000 2
store  1 00000025 0000ffff 1
store  2 00000026 ffffffff 1
store  3 00000020 ffffffff 2
load   2 00000020 7e5ca5a0 0
load   2 00000024 12345678 0
store  2 00000004 deadbeef 0
store  0 00000040 00000011 0
load   2 00000080 03020100 0
shadow 0 00000004 deadbeef 0
shadow 0 00000000 83828180 0
load   2 00000004 deadbeef 0
shadow 0 00000040 c3c2c111 0
store  0 0000001f 0000005a 0
store  1 0000003c 0000beef 0
flush  0 00000000 00000000 0
shadow 0 0000001c 5a9e9d9c 0
shadow 0 0000003c bfbebeef 0
load   2 0000003c bfbebeef 0

// File: flist.f
source/cache_pkg.sv
source/cache_load_gen.sv
source/cache_store_gen.sv
source/cache_ways.sv
source/cache_ctrl.sv
source/cache_top.sv
sim/cache_asserts.sv
sim/cache_tb.sv

// File: Makefile
.PHONY: sim clean

# Build with Verilator, run, and pass only if the pass line appears
sim:
	verilator --binary --assert -Wno-fatal --top-module cache_tb -Mdir obj_dir -f flist.f
	out=$$(./obj_dir/Vcache_tb +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
